// File: verilog/uart_rx_pkg.sv
// Shared types for the UART receive path
// Frames are 8 data bits LSB first with optional even parity and one stop bit
package uart_rx_pkg;

  // Widths with a meaning
  typedef logic [7:0]  uart_char_t;  // One received character
  typedef logic [7:0]  line_cnt_t;   // Complete lines waiting in the FIFO
  typedef logic [31:0] wb_data_t;
  typedef logic [1:0]  wb_addr_t;    // Word address

  // What the sampler just took from the line
  typedef enum logic [1:0] {
    bit_data,
    bit_parity,
    bit_stop
  } bit_kind_e;

  typedef struct packed {
    logic      value;
    bit_kind_e kind;
    logic [2:0] idx;  // Data bit position only
  } rx_bit_t;

  typedef struct packed {
    uart_char_t data;
    logic       parity_err;
    logic       frame_err;
    logic       eol;         // Set by the line buffer only
  } rx_char_t;

  // Forced end of line after this many characters
  localparam int max_line_chars = 254;

  // Register map
  localparam wb_addr_t reg_data   = 2'd0;
  localparam wb_addr_t reg_status = 2'd1;
  localparam wb_addr_t reg_ctrl   = 2'd2;

endpackage

// File: verilog/uart_rx_sampler.sv
// Bit sampler. clk_div must be at least 4
// Dropping rx_en aborts a frame in progress
`timescale 1ns/1ps

module uart_rx_sampler import uart_rx_pkg::*; #(
  parameter int clk_div   = 868,
  parameter int parity_en = 1
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    rx,
  input  logic    rx_en,
  output logic    bit_valid,
  output rx_bit_t bit_out
);

  localparam int cnt_w = $clog2(clk_div);
  localparam logic [cnt_w-1:0] cnt_full = cnt_w'(clk_div - 1);
  localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clk_div / 2 - 1);

  typedef enum logic [2:0] {idle, start, data, parity, stop} state_e;

  state_e           state;
  logic [1:0]       rx_sync;
  logic             rx_prev;
  logic [cnt_w-1:0] cnt;
  logic [2:0]       bit_cnt;
  logic             rx_s;
  logic             tick;
  logic             fall;

  assign rx_s = rx_sync[1];
  assign tick = (cnt == cnt_full);  // One bit period since last sample
  assign fall = rx_prev & ~rx_s;

  // Two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_sync <= 2'b11;  // Line idles high
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      cnt       <= '0;
      bit_cnt   <= '0;
      bit_valid <= 1'b0;
      bit_out   <= '0;
    end else begin
      bit_valid <= 1'b0;
      cnt       <= cnt + 1'b1;
      if (!rx_en) begin
        state   <= idle;
        cnt     <= '0;
        bit_cnt <= '0;
      end else begin
        case (state)
          idle: begin
            cnt     <= '0;
            bit_cnt <= '0;
            if (fall) state <= start;
          end
          start: if (cnt == cnt_half) begin  // Mid start bit
            cnt   <= '0;
            state <= rx_s ? idle : data;     // High again means a glitch
          end
          data: if (tick) begin
            cnt       <= '0;
            bit_valid <= 1'b1;
            bit_out   <= '{value: rx_s, kind: bit_data, idx: bit_cnt};
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= (parity_en != 0) ? parity : stop;
          end
          parity: if (tick) begin
            cnt       <= '0;
            bit_valid <= 1'b1;
            bit_out   <= '{value: rx_s, kind: bit_parity, idx: 3'd0};
            state     <= stop;
          end
          stop: if (tick) begin
            cnt       <= '0;
            bit_valid <= 1'b1;
            bit_out   <= '{value: rx_s, kind: bit_stop, idx: 3'd0};
            state     <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // Deframer has no back-pressure, so strobes must stay isolated
  a_single_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    bit_valid |=> !bit_valid);

endmodule

// File: verilog/uart_rx_deframer.sv
// Byte assembly and error flags
// Relies on the sampler's labels alone for frame structure
`timescale 1ns/1ps

module uart_rx_deframer import uart_rx_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     bit_valid,
  input  rx_bit_t  bit_in,
  output logic     char_valid,
  output rx_char_t char_out
);

  uart_char_t shift_q;
  logic       par_q;       // Running XOR of data and parity bits
  logic       par_seen_q;  // A parity bit belongs to this frame

  // Control side
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      char_valid <= 1'b0;
      par_q      <= 1'b0;
      par_seen_q <= 1'b0;
    end else begin
      char_valid <= 1'b0;
      if (bit_valid) begin
        case (bit_in.kind)
          bit_data: begin
            if (bit_in.idx == 3'd0) begin
              // First data bit restarts the frame
              par_q      <= bit_in.value;
              par_seen_q <= 1'b0;
            end else begin
              par_q <= par_q ^ bit_in.value;
            end
          end
          bit_parity: begin
            par_q      <= par_q ^ bit_in.value;
            par_seen_q <= 1'b1;
          end
          bit_stop: char_valid <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (bit_valid) begin
      if (bit_in.kind == bit_data) shift_q[bit_in.idx] <= bit_in.value;
      if (bit_in.kind == bit_stop) begin
        char_out.data       <= shift_q;
        char_out.parity_err <= par_seen_q & par_q;  // Even parity gives zero
        char_out.frame_err  <= ~bit_in.value;
        char_out.eol        <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/uart_rx_line_buffer.sv
// Character FIFO with end-of-line marking
// fifo_depth is a power of two between 2 and 128
`timescale 1ns/1ps

module uart_rx_line_buffer import uart_rx_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        rx_en,
  input  logic                        char_valid,
  input  rx_char_t                    char_in,
  input  logic                        pop,
  input  logic                        clr_overflow,
  output rx_char_t                    head,
  output logic                        empty,
  output logic [$clog2(fifo_depth):0] level,
  output line_cnt_t                   lines,
  output logic                        overflow
);

  localparam int aw = $clog2(fifo_depth);
  localparam logic [aw:0] depth_lv = (aw + 1)'(fifo_depth);

  rx_char_t      mem [fifo_depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [7:0]    char_cnt;  // Characters so far in the current line
  rx_char_t      wr_q;
  logic          wr_valid;
  logic          is_eol;
  logic          full;
  logic          push;
  logic          pop_ok;

  assign is_eol = (char_in.data == 8'h0A) || (char_cnt == 8'(max_line_chars - 1));
  assign full   = (level == depth_lv);
  assign empty  = (level == '0);
  assign push   = wr_valid & ~full;
  assign pop_ok = pop & ~empty;   // Pop on empty is ignored
  assign head   = mem[rd_ptr];

  // Marking stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      char_cnt <= '0;
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= char_valid;
      if (!rx_en) char_cnt <= '0;
      else if (char_valid) char_cnt <= is_eol ? 8'd0 : char_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (char_valid) wr_q <= '{data: char_in.data, parity_err: char_in.parity_err,
                              frame_err: char_in.frame_err, eol: is_eol};
    if (push) mem[wr_ptr] <= wr_q;
  end

  // Pointers and counts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      lines    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push)   wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      level <= level + (aw + 1)'(push) - (aw + 1)'(pop_ok);
      lines <= lines + line_cnt_t'(push & wr_q.eol) - line_cnt_t'(pop_ok & head.eol);
      if (wr_valid && full) overflow <= 1'b1;  // Character dropped
      else if (clr_overflow) overflow <= 1'b0;
    end
  end

  a_level_bound: assert property (@(posedge clk) disable iff (!arst_n)
    level <= depth_lv);
  a_lines_bound: assert property (@(posedge clk) disable iff (!arst_n)
    lines <= line_cnt_t'(level));

endmodule

// File: verilog/uart_rx_wb_regs.sv
// Wishbone classic slave with one wait state on every access
// Reading data from an empty FIFO returns zero
`timescale 1ns/1ps

module uart_rx_wb_regs import uart_rx_pkg::*; #(
  parameter int fifo_depth = 16
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  wb_addr_t                    wb_adr,
  input  wb_data_t                    wb_dat_w,
  output wb_data_t                    wb_dat_r,
  output logic                        wb_ack,
  output logic                        rx_en,
  input  rx_char_t                    head,
  input  logic                        empty,
  input  logic [$clog2(fifo_depth):0] level,
  input  line_cnt_t                   lines,
  input  logic                        overflow,
  output logic                        pop,
  output logic                        clr_overflow
);

  localparam int lvl_w = $clog2(fifo_depth) + 1;

  logic     req;
  wb_data_t rd_data;

  assign req = wb_cyc & wb_stb & ~wb_ack;  // Ack lasts a single clock

  // Read mux
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      reg_data: begin
        if (!empty) rd_data[10:0] = {head.eol, head.frame_err, head.parity_err, head.data};
      end
      reg_status: begin
        rd_data[0]            = empty;
        rd_data[1]            = overflow;
        rd_data[8 +: lvl_w]   = level;
        rd_data[23:16]        = lines;
      end
      reg_ctrl: rd_data[0] = rx_en;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      rx_en        <= 1'b0;
      pop          <= 1'b0;
      clr_overflow <= 1'b0;
    end else begin
      wb_ack       <= req;
      pop          <= 1'b0;
      clr_overflow <= 1'b0;
      if (req) begin
        if (wb_we) begin
          if (wb_adr == reg_ctrl) rx_en <= wb_dat_w[0];
          if (wb_adr == reg_status) clr_overflow <= wb_dat_w[1];
        end else begin
          wb_dat_r <= rd_data;
          pop      <= (wb_adr == reg_data) && !empty;  // Head leaves on the ack clock
        end
      end
    end
  end

  // The character returned on a data read must still be queued when it is popped
  a_pop_has_head: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> !empty);

endmodule

// File: verilog/uart_rx_top.sv
// UART receive subsystem with no transmit path
// Baud rate is fixed by clk_div
// Parity is even when parity_en is set
`timescale 1ns/1ps

module uart_rx_top import uart_rx_pkg::*; #(
  parameter int clk_div    = 868,
  parameter int parity_en  = 1,
  parameter int fifo_depth = 16
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     rx,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  wb_data_t wb_dat_w,
  output wb_data_t wb_dat_r,
  output logic     wb_ack
);

  logic                        rx_en;
  logic                        bit_valid;
  rx_bit_t                     bit_w;
  logic                        char_valid;
  rx_char_t                    char_w;
  rx_char_t                    head;
  logic                        empty;
  logic [$clog2(fifo_depth):0] level;
  line_cnt_t                   lines;
  logic                        overflow;
  logic                        pop;
  logic                        clr_overflow;

  uart_rx_sampler #(.clk_div(clk_div), .parity_en(parity_en)) i_sampler (
    .clk, .arst_n, .rx, .rx_en, .bit_valid, .bit_out(bit_w)
  );

  uart_rx_deframer i_deframer (
    .clk, .arst_n, .bit_valid, .bit_in(bit_w), .char_valid, .char_out(char_w)
  );

  uart_rx_line_buffer #(.fifo_depth(fifo_depth)) i_line_buffer (
    .clk, .arst_n, .rx_en, .char_valid, .char_in(char_w), .pop, .clr_overflow,
    .head, .empty, .level, .lines, .overflow
  );

  uart_rx_wb_regs #(.fifo_depth(fifo_depth)) i_wb_regs (
    .clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .rx_en, .head, .empty, .level, .lines, .overflow, .pop, .clr_overflow
  );

endmodule

// File: bench/tb_uart_rx.sv
// Testbench for the UART receive subsystem
// Must run from the project root to find bench/uart_rx_trace.txt
// The trace opens with comment lines that name its columns
`timescale 1ns/1ps

module tb_uart_rx import uart_rx_pkg::*; ();

  localparam int clk_div    = 8;
  localparam int clk_period = 4;  // ns

  logic     clk;
  logic     arst_n;
  logic     rx;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic     wb_ack;

  // Parsed trace with one entry per command
  logic [7:0]     cmd_q[$];
  logic [255:0]   name_q[$];
  int             a0_q[$];
  int             a1_q[$];
  int             a2_q[$];
  int             a3_q[$];
  longint         total_chars = 0;
  time            wd_limit;
  bit             loaded = 1'b0;
  int unsigned    lcg_state = 32'd81400;
  logic [255:0]   test_name = '0;
  int             test_errors = 0;
  int             errors = 0;
  int             checks = 0;
  int             tests_passed = 0;
  int             tests_failed = 0;

  uart_rx_top #(.clk_div(clk_div), .parity_en(1), .fifo_depth(16)) i_uart_rx_top (
    .clk(clk), .arst_n(arst_n), .rx(rx), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic load_trace();
    int           fd;
    int           n;
    int           a0;
    int           a1;
    int           a2;
    int           a3;
    logic [255:0] tok;
    logic [255:0] name;
    logic [959:0] rest;
    fd = $fopen("bench/uart_rx_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file bench/uart_rx_trace.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %s", tok) == 1) begin
        name = '0;
        a0 = 0;
        a1 = 0;
        a2 = 0;
        a3 = 0;
        case (tok)
          "#": n = $fgets(rest, fd);  // Comment line is skipped
          "N": n = $fscanf(fd, " %s", name);
          "T": n = $fscanf(fd, " %h %d %d", a0, a1, a2);
          "R": n = $fscanf(fd, " %h %d %d %d", a0, a1, a2, a3);
          "B": n = $fscanf(fd, " %d %h", a0, a1);
          "S": n = $fscanf(fd, " %d %d %d", a0, a1, a2);
          "E": n = $fscanf(fd, " %d", a0);
          "C": n = 0;
          default: begin
            $display("Unknown trace command %0s", tok);
            errors++;
          end
        endcase
        if (tok != "#") begin
          cmd_q.push_back(tok[7:0]);
          name_q.push_back(name);
          a0_q.push_back(a0);
          a1_q.push_back(a1);
          a2_q.push_back(a2);
          a3_q.push_back(a3);
          if (tok == "T") total_chars += 1;
          if (tok == "B") total_chars += a0;
        end
      end
      $fclose(fd);
    end
  endtask

  // One Wishbone classic access driven on the falling edge
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 8);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack) begin
      $display("At %0d ns the bus access to register %0d got no acknowledge", $time, adr);
      note_error();
    end
  endtask

  // Start, 8 data bits LSB first, even parity, stop
  task automatic send_frame(input uart_char_t b, input bit bad_par, input bit bad_stop);
    logic [10:0] bits;
    int          gap;
    gap  = lcg_next() % 8;
    bits = {~bad_stop, (^b) ^ bad_par, b, 1'b0};
    repeat (gap + 1) @(negedge clk);
    for (int i = 0; i < 11; i++) begin
      rx = bits[i];
      repeat (clk_div) @(negedge clk);
    end
    rx = 1'b1;
    if (bad_stop) repeat (clk_div) @(negedge clk);  // Give the next start bit an edge
  endtask

  task automatic read_char(input uart_char_t b, input logic pe, input logic fe,
                           input logic eol);
    wb_data_t dat;
    wb_data_t exp;
    time      deadline;
    deadline = $time + 40 * clk_div * clk_period;
    dat      = 32'h1;
    while (dat[0] && $time < deadline) bus_cycle(1'b0, reg_status, '0, dat);
    if (dat[0]) begin
      $display("At %0d ns no character arrived within 40 bit periods", $time);
      note_error();
    end else begin
      bus_cycle(1'b0, reg_data, '0, dat);
      exp = {21'd0, eol, fe, pe, b};
      checks++;
      if (dat !== exp) begin
        $display("Mismatch at %0d ns: data read expected %h, got %h", $time, exp, dat);
        note_error();
      end
    end
  endtask

  task automatic check_status(input int lines, input int ovf, input int level);
    wb_data_t dat;
    wb_data_t exp;
    repeat (clk_div / 2 + 6) @(negedge clk);  // Longest delay from mid stop bit to the FIFO
    bus_cycle(1'b0, reg_status, '0, dat);
    exp = {8'd0, 8'(lines), 8'(level), 6'd0, 1'(ovf), level == 0};
    checks++;
    if (dat !== exp) begin
      $display("Mismatch at %0d ns: status read expected %h, got %h", $time, exp, dat);
      note_error();
    end
  endtask

  // Writes the receive enable and reads it back from the control register
  task automatic write_rx_enable(input logic en);
    wb_data_t dat;
    wb_data_t exp;
    bus_cycle(1'b1, reg_ctrl, {31'd0, en}, dat);
    bus_cycle(1'b0, reg_ctrl, '0, dat);
    exp = {31'd0, en};
    checks++;
    if (dat !== exp) begin
      $display("Mismatch at %0d ns: control read expected %h, got %h", $time, exp, dat);
      note_error();
    end
  endtask

  task automatic end_test();
    if (test_name != '0) begin
      if (test_errors == 0) begin
        $display("Test %0s: pass", test_name);
        tests_passed++;
      end else begin
        $display("Test %0s: fail with %0d errors", test_name, test_errors);
        tests_failed++;
      end
    end
    test_errors = 0;
  endtask

  // Watchdog sized from the number of characters in the trace
  initial begin
    wait (loaded);
    #(wd_limit);
    $display("Watchdog expired at %0d ns before the trace finished", $time);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    wb_data_t dat;
    arst_n   = 1'b0;
    rx       = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    load_trace();
    wd_limit = total_chars * 11 * clk_div * clk_period * 3 + 20000;
    loaded   = 1'b1;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (int k = 0; k < cmd_q.size(); k++) begin
      case (cmd_q[k])
        "N": begin
          end_test();
          test_name = name_q[k];
        end
        "T": send_frame(a0_q[k][7:0], a1_q[k][0], a2_q[k][0]);
        "R": read_char(a0_q[k][7:0], a1_q[k][0], a2_q[k][0], a3_q[k][0]);
        "B": for (int i = 0; i < a0_q[k]; i++) begin
          send_frame(a1_q[k][7:0], 1'b0, 1'b0);
          read_char(a1_q[k][7:0], 1'b0, 1'b0, i == a0_q[k] - 1);
        end
        "S": check_status(a0_q[k], a1_q[k], a2_q[k]);
        "C": bus_cycle(1'b1, reg_status, 32'h2, dat);
        "E": write_rx_enable(a0_q[k][0]);
        default: ;
      endcase
    end
    end_test();
    if (checks == 0) begin
      $display("No checks were run, the trace held no reads");
      errors++;
    end
    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: bench/uart_rx_trace.txt
# Columns: N name | T byte bad_parity bad_stop | R byte parity_err frame_err eol
# B count byte | S lines overflow level | C clears overflow | E rx_en, bytes in hex
N basic_chars
E 1
T 48 0 0
T 69 0 0
T 7E 0 0
R 48 0 0 0
R 69 0 0 0
R 7E 0 0 0
S 0 0 0
N error_flags
T 5A 1 0
T C3 0 1
T 00 0 0
R 5A 1 0 0
R C3 0 1 0
R 00 0 0 0
N line_feed
T 41 0 0
T 0A 0 0
S 1 0 2
R 41 0 0 0
S 1 0 1
R 0A 0 0 1
S 0 0 0
N forced_eol
B 254 55
S 0 0 0
N overflow
T 30 0 0
T 31 0 0
T 32 0 0
T 33 0 0
T 34 0 0
T 35 0 0
T 36 0 0
T 37 0 0
T 38 0 0
T 39 0 0
T 3A 0 0
T 3B 0 0
T 3C 0 0
T 3D 0 0
T 3E 0 0
T 3F 0 0
T 40 0 0
S 0 1 16
R 30 0 0 0
R 31 0 0 0
R 32 0 0 0
R 33 0 0 0
R 34 0 0 0
R 35 0 0 0
R 36 0 0 0
R 37 0 0 0
R 38 0 0 0
R 39 0 0 0
R 3A 0 0 0
R 3B 0 0 0
R 3C 0 0 0
R 3D 0 0 0
R 3E 0 0 0
R 3F 0 0 0
S 0 1 0
C
S 0 0 0
N rx_enable
T 31 0 0
T 32 0 0
T 33 0 0
R 31 0 0 0
R 32 0 0 0
R 33 0 0 0
E 0
T 61 0 0
T 62 0 0
S 0 0 0
E 1
B 254 4D
S 0 0 0

// File: vlog.f
verilog/uart_rx_pkg.sv
verilog/uart_rx_sampler.sv
verilog/uart_rx_deframer.sv
verilog/uart_rx_line_buffer.sv
verilog/uart_rx_wb_regs.sv
verilog/uart_rx_top.sv
bench/tb_uart_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --assert -Wno-fatal --top-module tb_uart_rx \
  -f vlog.f -o sim_uart_rx

out=$(./obj_dir/sim_uart_rx)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
